// ==== verilog/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	localparam int XLEN = 32;
	localparam int REG_BITS = 5;

	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_ORI = 6'b001101;
	localparam logic [5:0] OP_LUI = 6'b001111;
	localparam logic [5:0] OP_LW = 6'b100011;
	localparam logic [5:0] OP_SW = 6'b101011;
	localparam logic [5:0] OP_BEQ = 6'b000100;
	localparam logic [5:0] OP_BNE = 6'b000101;
	localparam logic [5:0] OP_J = 6'b000010;

	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR = 6'b100101;
	localparam logic [5:0] FN_SLT = 6'b101010;

	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR = 3'd3;
	localparam logic [2:0] ALU_SLT = 3'd4;
	localparam logic [2:0] ALU_LUI = 3'd5;

	localparam logic [1:0] FWD_NONE = 2'd0;
	localparam logic [1:0] FWD_MEM = 2'd1;
	localparam logic [1:0] FWD_WB = 2'd2;

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [REG_BITS-1:0] rs;
			logic [REG_BITS-1:0] rt;
			logic [REG_BITS-1:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [REG_BITS-1:0] rs;
			logic [REG_BITS-1:0] rt;
			logic [15:0] imm16;
		} i;
		struct packed {
			logic [5:0] opcode;
			logic [25:0] index26;
		} j;
	} instrWord_u;

endpackage

`default_nettype wire

// ==== verilog/hazardIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hazardIf (input logic clk);

	logic [mipsPkg::REG_BITS-1:0] rsD, rtD;
	logic branchD, jumpRegUse;
	logic [mipsPkg::REG_BITS-1:0] rsE, rtE, writeRegE;
	logic regWriteE, memToRegE;
	logic [mipsPkg::REG_BITS-1:0] writeRegM, writeRegW;
	logic regWriteM, memToRegM, regWriteW;
	logic stallF, stallD, flushE;
	logic [1:0] forwardAD, forwardBD, forwardAE, forwardBE;

	modport fetch (input stallF, stallD);
	modport decode (output rsD, rtD, branchD, jumpRegUse, input forwardAD, forwardBD, flushE);
	modport execute (output rsE, rtE, writeRegE, regWriteE, memToRegE, input forwardAE, forwardBE);
	modport memWb (output writeRegM, regWriteM, memToRegM, writeRegW, regWriteW);
	modport hazard (
		input clk, rsD, rtD, branchD, jumpRegUse, rsE, rtE, writeRegE, regWriteE, memToRegE,
		input writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
		output stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
	);

endinterface

`default_nettype wire

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
	parameter logic [mipsPkg::XLEN-1:0] RESET_PC = 32'hbfc00000
) (
	input logic clk,
	input logic rstN_i,
	input logic redirect_i,
	input logic [mipsPkg::XLEN-1:0] redirectPc_i,
	input logic [mipsPkg::XLEN-1:0] instr_i,
	hazardIf.fetch hz,
	output logic [mipsPkg::XLEN-1:0] pc_o,
	output logic [mipsPkg::XLEN-1:0] instrD_o,
	output logic [mipsPkg::XLEN-1:0] pcPlus4D_o
);

	logic [mipsPkg::XLEN-1:0] pcPlus4;

	assign pcPlus4 = pc_o + 32'd4;

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i)
			pc_o <= RESET_PC;
		else if (!hz.stallF)
			pc_o <= redirect_i ? redirectPc_i : pcPlus4;
	end

	// All-zero word decodes as a no-op
	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i)
			instrD_o <= '0;
		else if (!hz.stallD)
			instrD_o <= instr_i;
	end

	always_ff @(posedge clk) begin
		if (!hz.stallD)
			pcPlus4D_o <= pcPlus4;
	end

	// While stalled a redirect is dropped and the branch repeats in decode
	assert property (@(posedge clk) disable iff (!rstN_i)
		(redirect_i && hz.stallF) |=> ($stable(pc_o) && $stable(instrD_o)));

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input logic clk,
	input logic rstN_i,
	input logic [mipsPkg::XLEN-1:0] instrD_i,
	input logic [mipsPkg::XLEN-1:0] pcPlus4D_i,
	input logic wbWe_i,
	input logic [mipsPkg::REG_BITS-1:0] wbAddr_i,
	input logic [mipsPkg::XLEN-1:0] wbData_i,
	input logic [mipsPkg::XLEN-1:0] aluOutM_i,
	hazardIf.decode hz,
	output logic redirect_o,
	output logic [mipsPkg::XLEN-1:0] redirectPc_o,
	output logic [2:0] aluOpE_o,
	output logic aluSrcImmE_o,
	output logic regDstRdE_o,
	output logic memWriteE_o,
	output logic memToRegE_o,
	output logic regWriteE_o,
	output logic [mipsPkg::XLEN-1:0] srcAE_o,
	output logic [mipsPkg::XLEN-1:0] srcBE_o,
	output logic [mipsPkg::XLEN-1:0] immE_o,
	output logic [mipsPkg::REG_BITS-1:0] rsE_o,
	output logic [mipsPkg::REG_BITS-1:0] rtE_o,
	output logic [mipsPkg::REG_BITS-1:0] rdE_o,
	output logic [mipsPkg::XLEN-1:0] pcE_o
);

	mipsPkg::instrWord_u instr;
	logic [mipsPkg::XLEN-1:0] regFile [2**mipsPkg::REG_BITS];
	logic [mipsPkg::XLEN-1:0] rsVal, rtVal, cmpA, cmpB, immD;
	logic [2:0] aluOpD;
	logic aluSrcImmD, regDstRdD, memWriteD, memToRegD, regWriteD;
	logic zeroExtD, beqD, bneD, jumpD, readsRegD, taken;

	assign instr = instrD_i;

	always_comb begin
		aluOpD = mipsPkg::ALU_ADD;
		aluSrcImmD = 1'b0;
		regDstRdD = 1'b0;
		memWriteD = 1'b0;
		memToRegD = 1'b0;
		regWriteD = 1'b0;
		zeroExtD = 1'b0;
		beqD = 1'b0;
		bneD = 1'b0;
		jumpD = 1'b0;
		readsRegD = 1'b1;
		case (instr.r.opcode)
			mipsPkg::OP_RTYPE: begin
				regDstRdD = 1'b1;
				regWriteD = 1'b1;
				case (instr.r.funct)
					mipsPkg::FN_ADDU: aluOpD = mipsPkg::ALU_ADD;
					mipsPkg::FN_SUBU: aluOpD = mipsPkg::ALU_SUB;
					mipsPkg::FN_AND: aluOpD = mipsPkg::ALU_AND;
					mipsPkg::FN_OR: aluOpD = mipsPkg::ALU_OR;
					mipsPkg::FN_SLT: aluOpD = mipsPkg::ALU_SLT;
					default: regWriteD = 1'b0;
				endcase
			end
			mipsPkg::OP_ADDIU: begin
				aluSrcImmD = 1'b1;
				regWriteD = 1'b1;
			end
			mipsPkg::OP_ORI: begin
				aluOpD = mipsPkg::ALU_OR;
				aluSrcImmD = 1'b1;
				zeroExtD = 1'b1;
				regWriteD = 1'b1;
			end
			mipsPkg::OP_LUI: begin
				aluOpD = mipsPkg::ALU_LUI;
				aluSrcImmD = 1'b1;
				zeroExtD = 1'b1;
				regWriteD = 1'b1;
				readsRegD = 1'b0;
			end
			mipsPkg::OP_LW: begin
				aluSrcImmD = 1'b1;
				memToRegD = 1'b1;
				regWriteD = 1'b1;
			end
			mipsPkg::OP_SW: begin
				aluSrcImmD = 1'b1;
				memWriteD = 1'b1;
			end
			mipsPkg::OP_BEQ: beqD = 1'b1;
			mipsPkg::OP_BNE: bneD = 1'b1;
			mipsPkg::OP_J: begin
				jumpD = 1'b1;
				readsRegD = 1'b0;
			end
			default: readsRegD = 1'b0;
		endcase
	end

	assign immD = zeroExtD ? {16'b0, instr.i.imm16} : {{16{instr.i.imm16[15]}}, instr.i.imm16};

	// Written mid-cycle so decode sees the writeback value
	always_ff @(negedge clk) begin
		if (wbWe_i)
			regFile[wbAddr_i] <= wbData_i;
	end

	assign rsVal = (instr.r.rs == '0) ? '0 : regFile[instr.r.rs];
	assign rtVal = (instr.r.rt == '0) ? '0 : regFile[instr.r.rt];

	// Branch comparator
	assign cmpA = (hz.forwardAD == mipsPkg::FWD_MEM) ? aluOutM_i : rsVal;
	assign cmpB = (hz.forwardBD == mipsPkg::FWD_MEM) ? aluOutM_i : rtVal;
	assign taken = (beqD && cmpA == cmpB) || (bneD && cmpA != cmpB);

	assign redirect_o = taken || jumpD;
	assign redirectPc_o = jumpD ? {pcPlus4D_i[31:28], instr.j.index26, 2'b00}
		: pcPlus4D_i + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};

	assign hz.rsD = instr.r.rs;
	assign hz.rtD = instr.r.rt;
	assign hz.branchD = beqD || bneD;
	assign hz.jumpRegUse = readsRegD;

	// ID/EX
	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			memWriteE_o <= 1'b0;
			memToRegE_o <= 1'b0;
			regWriteE_o <= 1'b0;
		end else if (hz.flushE) begin
			memWriteE_o <= 1'b0;
			memToRegE_o <= 1'b0;
			regWriteE_o <= 1'b0;
		end else begin
			memWriteE_o <= memWriteD;
			memToRegE_o <= memToRegD;
			regWriteE_o <= regWriteD;
		end
	end

	always_ff @(posedge clk) begin
		aluOpE_o <= aluOpD;
		aluSrcImmE_o <= aluSrcImmD;
		regDstRdE_o <= regDstRdD;
		srcAE_o <= rsVal;
		srcBE_o <= rtVal;
		immE_o <= immD;
		rsE_o <= instr.r.rs;
		rtE_o <= instr.r.rt;
		rdE_o <= instr.r.rd;
		pcE_o <= pcPlus4D_i - 32'd4;
	end

	// Holds only while the hazard unit never forwards onto r0
	assert property (@(posedge clk) disable iff (!rstN_i)
		(instr.r.rs == '0) |-> (cmpA == '0));

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input logic clk,
	input logic rstN_i,
	input logic [2:0] aluOpE_i,
	input logic aluSrcImmE_i,
	input logic regDstRdE_i,
	input logic memWriteE_i,
	input logic memToRegE_i,
	input logic regWriteE_i,
	input logic [mipsPkg::XLEN-1:0] srcAE_i,
	input logic [mipsPkg::XLEN-1:0] srcBE_i,
	input logic [mipsPkg::XLEN-1:0] immE_i,
	input logic [mipsPkg::REG_BITS-1:0] rsE_i,
	input logic [mipsPkg::REG_BITS-1:0] rtE_i,
	input logic [mipsPkg::REG_BITS-1:0] rdE_i,
	input logic [mipsPkg::XLEN-1:0] pcE_i,
	input logic [mipsPkg::XLEN-1:0] resultW_i,
	hazardIf.execute hz,
	output logic [mipsPkg::XLEN-1:0] aluOutM_o,
	output logic [mipsPkg::XLEN-1:0] writeDataM_o,
	output logic [mipsPkg::REG_BITS-1:0] writeRegM_o,
	output logic regWriteM_o,
	output logic memToRegM_o,
	output logic memWriteM_o,
	output logic [mipsPkg::XLEN-1:0] pcM_o
);

	logic [mipsPkg::XLEN-1:0] opA, opB, aluB, aluRes;
	logic [mipsPkg::REG_BITS-1:0] writeRegE;

	function automatic logic [mipsPkg::XLEN-1:0] fwdSel(
		input logic [1:0] sel,
		input logic [mipsPkg::XLEN-1:0] regVal,
		input logic [mipsPkg::XLEN-1:0] memVal,
		input logic [mipsPkg::XLEN-1:0] wbVal
	);
		case (sel)
			mipsPkg::FWD_MEM: return memVal;
			mipsPkg::FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = fwdSel(hz.forwardAE, srcAE_i, aluOutM_o, resultW_i);
	assign opB = fwdSel(hz.forwardBE, srcBE_i, aluOutM_o, resultW_i);
	assign aluB = aluSrcImmE_i ? immE_i : opB;

	always_comb begin
		case (aluOpE_i)
			mipsPkg::ALU_SUB: aluRes = opA - aluB;
			mipsPkg::ALU_AND: aluRes = opA & aluB;
			mipsPkg::ALU_OR: aluRes = opA | aluB;
			mipsPkg::ALU_SLT: aluRes = {{(mipsPkg::XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
			mipsPkg::ALU_LUI: aluRes = {aluB[15:0], 16'b0};
			default: aluRes = opA + aluB;
		endcase
	end

	assign writeRegE = regDstRdE_i ? rdE_i : rtE_i;

	assign hz.rsE = rsE_i;
	assign hz.rtE = rtE_i;
	assign hz.writeRegE = writeRegE;
	assign hz.regWriteE = regWriteE_i;
	assign hz.memToRegE = memToRegE_i;

	// EX/MEM
	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			regWriteM_o <= 1'b0;
			memToRegM_o <= 1'b0;
			memWriteM_o <= 1'b0;
		end else begin
			regWriteM_o <= regWriteE_i;
			memToRegM_o <= memToRegE_i;
			memWriteM_o <= memWriteE_i;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM_o <= aluRes;
		writeDataM_o <= opB;
		writeRegM_o <= writeRegE;
		pcM_o <= pcE_i;
	end

endmodule

`default_nettype wire

// ==== verilog/memWbStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
	input logic clk,
	input logic rstN_i,
	input logic [mipsPkg::XLEN-1:0] aluOutM_i,
	input logic [mipsPkg::XLEN-1:0] writeDataM_i,
	input logic [mipsPkg::REG_BITS-1:0] writeRegM_i,
	input logic regWriteM_i,
	input logic memToRegM_i,
	input logic memWriteM_i,
	input logic [mipsPkg::XLEN-1:0] pcM_i,
	output logic [3:0] dataSramWen_o,
	output logic [mipsPkg::XLEN-1:0] dataSramAddr_o,
	output logic [mipsPkg::XLEN-1:0] dataSramWdata_o,
	input logic [mipsPkg::XLEN-1:0] dataSramRdata_i,
	hazardIf.memWb hz,
	output logic wbWe_o,
	output logic [mipsPkg::REG_BITS-1:0] wbAddr_o,
	output logic [mipsPkg::XLEN-1:0] wbData_o,
	output logic [mipsPkg::XLEN-1:0] wbPc_o
);

	logic [mipsPkg::XLEN-1:0] aluOutW;
	logic regWriteW, memToRegW;

	// Full-word stores only; top bits dropped as a kseg fold
	assign dataSramWen_o = {4{memWriteM_i}};
	assign dataSramAddr_o = {3'b000, aluOutM_i[28:0]};
	assign dataSramWdata_o = writeDataM_i;

	assign hz.writeRegM = writeRegM_i;
	assign hz.regWriteM = regWriteM_i;
	assign hz.memToRegM = memToRegM_i;

	// MEM/WB
	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end else begin
			regWriteW <= regWriteM_i;
			memToRegW <= memToRegM_i;
		end
	end

	always_ff @(posedge clk) begin
		aluOutW <= aluOutM_i;
		wbAddr_o <= writeRegM_i;
		wbPc_o <= pcM_i;
	end

	// Load data arrives from the SRAM this cycle
	assign wbData_o = memToRegW ? dataSramRdata_i : aluOutW;
	assign wbWe_o = regWriteW && (wbAddr_o != '0);

	assign hz.writeRegW = wbAddr_o;
	assign hz.regWriteW = wbWe_o;

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	hazardIf.hazard hz
);

	logic loadUse, branchOnE, branchOnM, stall;

	function automatic logic [1:0] exFwd(input logic [mipsPkg::REG_BITS-1:0] src);
		if (src != '0 && hz.regWriteM && src == hz.writeRegM)
			return mipsPkg::FWD_MEM;
		if (src != '0 && hz.regWriteW && src == hz.writeRegW)
			return mipsPkg::FWD_WB;
		return mipsPkg::FWD_NONE;
	endfunction

	// Load results are not ready in memory
	function automatic logic [1:0] idFwd(input logic [mipsPkg::REG_BITS-1:0] src);
		if (src != '0 && hz.regWriteM && !hz.memToRegM && src == hz.writeRegM)
			return mipsPkg::FWD_MEM;
		return mipsPkg::FWD_NONE;
	endfunction

	always_comb begin
		hz.forwardAE = exFwd(hz.rsE);
		hz.forwardBE = exFwd(hz.rtE);
		hz.forwardAD = idFwd(hz.rsD);
		hz.forwardBD = idFwd(hz.rtD);
	end

	assign loadUse = hz.memToRegE && hz.jumpRegUse
		&& (hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD);
	assign branchOnE = hz.branchD && hz.regWriteE && hz.writeRegE != '0
		&& (hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD);
	assign branchOnM = hz.branchD && hz.memToRegM
		&& (hz.writeRegM == hz.rsD || hz.writeRegM == hz.rtD);
	assign stall = loadUse || branchOnE || branchOnM;

	assign hz.stallF = stall;
	assign hz.stallD = stall;
	assign hz.flushE = stall;

	// Stalled instruction leaves a bubble in execute
	assert property (@(posedge hz.clk) hz.stallD |=> (!hz.regWriteE && !hz.memToRegE));

	// Worst case is a branch on a load in execute
	assert property (@(posedge hz.clk) hz.stallD [*2] |=> !hz.stallD);

endmodule

`default_nettype wire

// ==== verilog/mycpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mycpuTop #(
	parameter logic [31:0] RESET_PC = 32'hbfc00000
) (
	input logic clk,
	input logic rstN_i,
	output logic [31:0] instSramAddr_o,
	input logic [31:0] instSramRdata_i,
	output logic [3:0] dataSramWen_o,
	output logic [31:0] dataSramAddr_o,
	output logic [31:0] dataSramWdata_o,
	input logic [31:0] dataSramRdata_i,
	output logic [31:0] debugWbPc_o,
	output logic [3:0] debugWbRfWen_o,
	output logic [4:0] debugWbRfWnum_o,
	output logic [31:0] debugWbRfWdata_o
);

	logic [31:0] instrD, pcPlus4D, redirectPc;
	logic redirect;
	logic [2:0] aluOpE;
	logic aluSrcImmE, regDstRdE, memWriteE, memToRegE, regWriteE;
	logic [31:0] srcAE, srcBE, immE, pcE;
	logic [4:0] rsE, rtE, rdE;
	logic [31:0] aluOutM, writeDataM, pcM;
	logic [4:0] writeRegM;
	logic regWriteM, memToRegM, memWriteM;
	logic wbWe;
	logic [4:0] wbAddr;
	logic [31:0] wbData, wbPc;

	hazardIf hz (.clk(clk));

	fetchStage #(.RESET_PC(RESET_PC)) i_fetch (
		.clk(clk), .rstN_i(rstN_i),
		.redirect_i(redirect), .redirectPc_i(redirectPc),
		.instr_i(instSramRdata_i), .hz(hz.fetch),
		.pc_o(instSramAddr_o), .instrD_o(instrD), .pcPlus4D_o(pcPlus4D)
	);

	decodeStage i_decode (
		.clk(clk), .rstN_i(rstN_i),
		.instrD_i(instrD), .pcPlus4D_i(pcPlus4D),
		.wbWe_i(wbWe), .wbAddr_i(wbAddr), .wbData_i(wbData),
		.aluOutM_i(aluOutM), .hz(hz.decode),
		.redirect_o(redirect), .redirectPc_o(redirectPc),
		.aluOpE_o(aluOpE), .aluSrcImmE_o(aluSrcImmE), .regDstRdE_o(regDstRdE),
		.memWriteE_o(memWriteE), .memToRegE_o(memToRegE), .regWriteE_o(regWriteE),
		.srcAE_o(srcAE), .srcBE_o(srcBE), .immE_o(immE),
		.rsE_o(rsE), .rtE_o(rtE), .rdE_o(rdE), .pcE_o(pcE)
	);

	executeStage i_execute (
		.clk(clk), .rstN_i(rstN_i),
		.aluOpE_i(aluOpE), .aluSrcImmE_i(aluSrcImmE), .regDstRdE_i(regDstRdE),
		.memWriteE_i(memWriteE), .memToRegE_i(memToRegE), .regWriteE_i(regWriteE),
		.srcAE_i(srcAE), .srcBE_i(srcBE), .immE_i(immE),
		.rsE_i(rsE), .rtE_i(rtE), .rdE_i(rdE), .pcE_i(pcE),
		.resultW_i(wbData), .hz(hz.execute),
		.aluOutM_o(aluOutM), .writeDataM_o(writeDataM), .writeRegM_o(writeRegM),
		.regWriteM_o(regWriteM), .memToRegM_o(memToRegM), .memWriteM_o(memWriteM),
		.pcM_o(pcM)
	);

	memWbStage i_memWb (
		.clk(clk), .rstN_i(rstN_i),
		.aluOutM_i(aluOutM), .writeDataM_i(writeDataM), .writeRegM_i(writeRegM),
		.regWriteM_i(regWriteM), .memToRegM_i(memToRegM), .memWriteM_i(memWriteM),
		.pcM_i(pcM),
		.dataSramWen_o(dataSramWen_o), .dataSramAddr_o(dataSramAddr_o),
		.dataSramWdata_o(dataSramWdata_o), .dataSramRdata_i(dataSramRdata_i),
		.hz(hz.memWb),
		.wbWe_o(wbWe), .wbAddr_o(wbAddr), .wbData_o(wbData), .wbPc_o(wbPc)
	);

	hazardUnit i_hazard (.hz(hz.hazard));

	// Writeback trace
	assign debugWbPc_o = wbPc;
	assign debugWbRfWen_o = {4{wbWe}};
	assign debugWbRfWnum_o = wbAddr;
	assign debugWbRfWdata_o = wbData;

endmodule

`default_nettype wire

// ==== verification/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

	localparam int MEM_WORDS = 256;
	localparam logic [31:0] SEED = 32'hc1e4_f1ea;
	localparam logic [31:0] RESET_PC = 32'hbfc00000;
	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 8;
	// Section offsets in the test data image
	localparam int PROG_BASE = 'h10;
	localparam int DATA_BASE = 'h80;
	localparam int WB_BASE = 'ha0;
	localparam int STORE_BASE = 'hf0;

	logic clk;
	logic rstN;
	logic [31:0] instSramAddr, instSramRdata;
	logic [3:0] dataSramWen;
	logic [31:0] dataSramAddr, dataSramWdata, dataSramRdata;
	logic [31:0] debugWbPc, debugWbRfWdata;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;

	logic [31:0] testData [MEM_WORDS];
	logic [31:0] instMem [MEM_WORDS];
	logic [31:0] dataMem [MEM_WORDS];
	int progLen, dataLen, wbLen, storeLen;
	int wbSeen, storesSeen, errors;
	bit loaded;
	logic storeReq;
	logic [7:0] reqIdx;
	logic [31:0] reqData;

	mycpuTop #(.RESET_PC(RESET_PC)) i_dut (
		.clk(clk), .rstN_i(rstN),
		.instSramAddr_o(instSramAddr), .instSramRdata_i(instSramRdata),
		.dataSramWen_o(dataSramWen), .dataSramAddr_o(dataSramAddr),
		.dataSramWdata_o(dataSramWdata), .dataSramRdata_i(dataSramRdata),
		.debugWbPc_o(debugWbPc), .debugWbRfWen_o(debugWbRfWen),
		.debugWbRfWnum_o(debugWbRfWnum), .debugWbRfWdata_o(debugWbRfWdata)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic loadTestData();
		logic [31:0] state;
		$readmemh("verification/cpu_testdata.txt", testData);
		progLen = testData[0];
		dataLen = testData[1];
		wbLen = testData[2];
		storeLen = testData[3];
		state = SEED;
		// Each word mixes in its own byte address
		for (int i = 0; i < MEM_WORDS; i++) begin
			state = xorshift32(state ^ (i << 2));
			dataMem[i] = state;
			instMem[i] = '0;
		end
		for (int i = 0; i < progLen; i++)
			instMem[int'(RESET_PC[9:2]) + i] = testData[PROG_BASE + i];
		for (int i = 0; i < dataLen; i++)
			dataMem[testData[DATA_BASE + 2 * i][9:2]] = testData[DATA_BASE + 2 * i + 1];
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
	endtask

	task automatic checkWriteback();
		int entry;
		entry = WB_BASE + 3 * wbSeen;
		assert (wbSeen < wbLen) else begin
			errors++;
			$display("Unexpected writeback from pc %h to register %0d", debugWbPc, debugWbRfWnum);
		end
		if (wbSeen < wbLen) begin
			assert (debugWbRfWen == 4'hf)
				else reportMismatch("debugWbRfWen", {28'b0, debugWbRfWen}, 32'hf);
			assert (debugWbPc == testData[entry])
				else reportMismatch("debugWbPc", debugWbPc, testData[entry]);
			assert (debugWbRfWnum == testData[entry + 1][4:0])
				else reportMismatch("debugWbRfWnum", {27'b0, debugWbRfWnum}, testData[entry + 1]);
			assert (debugWbRfWdata == testData[entry + 2])
				else reportMismatch("debugWbRfWdata", debugWbRfWdata, testData[entry + 2]);
			wbSeen++;
		end
	endtask

	task automatic checkStore();
		int entry;
		entry = STORE_BASE + 2 * storesSeen;
		assert (storesSeen < storeLen) else begin
			errors++;
			$display("Unexpected store of %h to address %h", dataSramWdata, dataSramAddr);
		end
		if (storesSeen < storeLen) begin
			assert (dataSramWen == 4'hf)
				else reportMismatch("dataSramWen", {28'b0, dataSramWen}, 32'hf);
			assert (dataSramAddr == testData[entry])
				else reportMismatch("dataSramAddr", dataSramAddr, testData[entry]);
			assert (dataSramWdata == testData[entry + 1])
				else reportMismatch("dataSramWdata", dataSramWdata, testData[entry + 1]);
			storesSeen++;
		end
	endtask

	task automatic finishRun();
		assert (wbSeen == wbLen) else begin
			errors++;
			$display("%0d expected writebacks never appeared", wbLen - wbSeen);
		end
		assert (storesSeen == storeLen) else begin
			errors++;
			$display("%0d expected stores never appeared", storeLen - storesSeen);
		end
		$display("Errors: %0d, writebacks %0d of %0d, stores %0d of %0d",
			errors, wbSeen, wbLen, storesSeen, storeLen);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	// Combinational instruction SRAM
	assign instSramRdata = instMem[instSramAddr[9:2]];

	// Mid-cycle sampling of the memory-stage request and the writeback trace
	always @(negedge clk) begin
		storeReq = (dataSramWen != 4'b0);
		reqIdx = dataSramAddr[9:2];
		reqData = dataSramWdata;
		if (!rstN) begin
			assert (debugWbRfWen == 4'b0 && dataSramWen == 4'b0) else begin
				errors++;
				$display("Writeback or store seen during reset at %0t", $time);
			end
			assert (instSramAddr == RESET_PC)
				else reportMismatch("instSramAddr", instSramAddr, RESET_PC);
		end else begin
			if (debugWbRfWen != 4'b0)
				checkWriteback();
			if (storeReq)
				checkStore();
		end
	end

	// Data SRAM answers one cycle later
	always @(posedge clk) begin
		#1;
		if (storeReq)
			dataMem[reqIdx] = reqData;
		dataSramRdata = dataMem[reqIdx];
	end

	initial begin
		rstN = 1'b0;
		dataSramRdata = '0;
		storeReq = 1'b0;
		reqIdx = '0;
		reqData = '0;
		errors = 0;
		wbSeen = 0;
		storesSeen = 0;
		loadTestData();
		assert (progLen > 0 && wbLen > 0) else begin
			errors++;
			$display("Test data file is missing or empty");
		end
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rstN = 1'b1;
		wait (wbSeen >= wbLen && storesSeen >= storeLen);
		// Room for stray writebacks after the last expected one
		repeat (DRAIN_CYCLES) @(posedge clk);
		finishRun();
	end

	initial begin
		int budget;
		wait (loaded);
		budget = RESET_CYCLES + (progLen + wbLen) * 4;
		repeat (budget) @(posedge clk);
		errors++;
		$display("Watchdog expired after %0d cycles, the program did not complete", budget);
		finishRun();
	end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/mipsPkg.sv
verilog/hazardIf.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/hazardUnit.sv
verilog/mycpuTop.sv
verification/cpuTb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP := cpuTb
FILELIST := sim.f
BUILD_DIR := obj_dir
LOG := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/cpu_testdata.txt ====
// Word image for cpuTb, read with $readmemh; each section starts at its @ offset
// @00 counts: program words, initial data words, writebacks, stores
@00
00000021 00000001 00000015 00000003
// @10 program words from the reset address, four per line
@10
3C011234 34215678 24020100 2403FFFD // lui ori addiu addiu
00232021 00812823 00A0302A 00243824 // addu subu slt and
00C74025 AC480000 AC410004 8C490000 // or sw sw lw
01295021 8C4B0008 15600002 240D0011 // addu(load-use) lw bne(on load) slot
240E0022 24000005 00026021 240F0007 // skipped, write r0, read r0, addiu
11ED0002 341000AA 341100BB 12100002 // beq not taken, slot, ori, beq taken
02119021 3413DEAD AC52000C 8C54000C // slot, skipped, sw, lw
8C550004 0BF0001F 02B4B023 0BF0001F // lw, j, slot with load-use, j self
00000000
// @80 initial data words: byte address, value
@80
00000108 CAFEF00D
// @a0 writeback trace: pc, register number, data
@a0
BFC00000 00000001 12340000
BFC00004 00000001 12345678
BFC00008 00000002 00000100
BFC0000C 00000003 FFFFFFFD
BFC00010 00000004 12345675
BFC00014 00000005 FFFFFFFD
BFC00018 00000006 00000001
BFC0001C 00000007 12345670
BFC00020 00000008 12345671
BFC0002C 00000009 12345671
BFC00030 0000000A 2468ACE2
BFC00034 0000000B CAFEF00D
BFC0003C 0000000D 00000011
BFC00048 0000000C 00000100
BFC0004C 0000000F 00000007
BFC00054 00000010 000000AA
BFC00058 00000011 000000BB
BFC00060 00000012 00000165
BFC0006C 00000014 00000165
BFC00070 00000015 12345678
BFC00078 00000016 12345513
// @f0 stores: byte address, data
@f0
00000100 12345671
00000104 12345678
0000010C 00000165
